// File: hdl/adc_stream_config.svh
`ifndef ADC_STREAM_CONFIG_SVH
`define ADC_STREAM_CONFIG_SVH

// tone synthesis
`define ADC_TONE_COUNT 8
`define ADC_CHANNEL_COUNT 32
// peak value of every tone
`define ADC_AMPLITUDE 32000
// rotation stages, atan table is sized for 16
`define CORDIC_STAGES 16

// phase steps per sample tick, full turn is 2^32
// 51 Hz
`define TONE_INC_0 32'd21907217
// 61 Hz
`define TONE_INC_1 32'd26202749
// 71 Hz
`define TONE_INC_2 32'd30498282
// 81 Hz
`define TONE_INC_3 32'd34793814
// 91 Hz
`define TONE_INC_4 32'd39089347
// 101 Hz
`define TONE_INC_5 32'd43384880
// 201 Hz
`define TONE_INC_6 32'd86340206
// 301 Hz
`define TONE_INC_7 32'd129295532

// local network address, 192.168.4.x
`define NET_IP_PREFIX 24'hc0a804
// host used when no jumper is fitted
`define NET_IP_DEFAULT_HOST 8'd100
// upper 40 bits of the local MAC
`define NET_MAC_PREFIX 40'h000a350001

`endif

// File: hdl/adc_stream_pkg.sv
package adc_stream_pkg;

	// phase, 2^32 per full turn
	typedef logic [31:0] phase_t;
	// signed sine sample
	typedef logic signed [15:0] sample_t;
	// tone number 0..7
	typedef logic [2:0] tone_idx_t;
	typedef logic [7:0] byte_t;
	// address jumpers, active low on the board
	typedef logic [4:0] jumper_t;
	typedef logic [31:0] ipv4_t;
	typedef logic [47:0] mac_t;

	// phase generator to cordic
	typedef struct packed {
		logic valid;
		logic last;
		tone_idx_t idx;
		phase_t phase;
	} tone_phase_t;

	// cordic to serializer
	typedef struct packed {
		logic valid;
		logic last;
		tone_idx_t idx;
		sample_t sample;
	} tone_sample_t;

	// local address for the MAC
	typedef struct packed {
		ipv4_t ip;
		mac_t mac;
	} net_addr_t;

	// frame output FSM
	typedef enum logic {
		ser_idle,
		ser_send
	} ser_state_e;

endpackage

// File: hdl/tone_phase_gen.sv
`timescale 1ns/1ps
`include "adc_stream_config.svh"

module tone_phase_gen (
	input logic tx_clk_b,
	input logic rst_n,
	input logic sample_tick,
	output adc_stream_pkg::tone_phase_t phase_out
);

	localparam adc_stream_pkg::tone_idx_t LAST_IDX = 3'(`ADC_TONE_COUNT - 1);

	// per tone phase step
	localparam adc_stream_pkg::phase_t TONE_INC [`ADC_TONE_COUNT] = '{
		`TONE_INC_0, `TONE_INC_1, `TONE_INC_2, `TONE_INC_3,
		`TONE_INC_4, `TONE_INC_5, `TONE_INC_6, `TONE_INC_7
	};

	adc_stream_pkg::phase_t acc [`ADC_TONE_COUNT];
	adc_stream_pkg::tone_idx_t issue_cnt;
	logic busy;

	logic vld_q;
	logic last_q;
	adc_stream_pkg::tone_idx_t idx_q;
	adc_stream_pkg::phase_t phase_q;

	// accumulators and issue sequencing
	always_ff @(posedge tx_clk_b) begin
		if (!rst_n) begin
			busy <= 1'b0;
			issue_cnt <= '0;
			vld_q <= 1'b0;
			for (int t = 0; t < `ADC_TONE_COUNT; t++) begin
				acc[t] <= '0;
			end
		end else begin
			vld_q <= busy;
			if (busy) begin
				issue_cnt <= issue_cnt + 3'd1;
				// done after tone 7
				if (issue_cnt == LAST_IDX) begin
					busy <= 1'b0;
				end
			end else if (sample_tick) begin
				// all tones step together, ticks while busy are dropped
				for (int t = 0; t < `ADC_TONE_COUNT; t++) begin
					acc[t] <= acc[t] + TONE_INC[t];
				end
				busy <= 1'b1;
				issue_cnt <= '0;
			end
		end
	end

	// one tone per cycle
	always_ff @(posedge tx_clk_b) begin
		last_q <= (issue_cnt == LAST_IDX);
		idx_q <= issue_cnt;
		phase_q <= acc[issue_cnt];
	end

	assign phase_out = '{valid: vld_q, last: last_q, idx: idx_q, phase: phase_q};

endmodule

// File: hdl/cordic_sine.sv
`timescale 1ns/1ps
`include "adc_stream_config.svh"

module cordic_sine (
	input logic tx_clk_b,
	input logic rst_n,
	input adc_stream_pkg::tone_phase_t phase_in,
	output adc_stream_pkg::tone_sample_t sine_out
);

	localparam int N = `CORDIC_STAGES;
	// two guard bits below the sample lsb
	localparam int FRAC = 2;
	localparam int XY_W = 16 + FRAC + 2;
	// gain of the rotation chain, Kn for 16 stages
	localparam real CORDIC_GAIN = 1.646760;
	localparam int START_MAG = int'(real'(`ADC_AMPLITUDE) * real'(1 << FRAC) / CORDIC_GAIN);

	// atan(2^-i) scaled to 2^32 per turn
	localparam adc_stream_pkg::phase_t ATAN [N] = '{
		32'd536870912, 32'd316933406, 32'd167458907, 32'd85004756,
		32'd42667331, 32'd21354465, 32'd10679838, 32'd5340245,
		32'd2670163, 32'd1335087, 32'd667544, 32'd333772,
		32'd166886, 32'd83443, 32'd41722, 32'd20861
	};

	// side data riding along the vector
	typedef struct packed {
		logic last;
		adc_stream_pkg::tone_idx_t idx;
		logic neg;
	} tag_t;

	logic vld_q [0:N];
	tag_t tag_q [0:N];
	logic signed [XY_W-1:0] x_q [0:N];
	logic signed [XY_W-1:0] y_q [0:N];
	adc_stream_pkg::phase_t z_q [0:N];
	logic signed [XY_W-1:0] y_fin;

	// valid chain, fixed latency N+1
	always_ff @(posedge tx_clk_b) begin
		if (!rst_n) begin
			for (int i = 0; i <= N; i++) begin
				vld_q[i] <= 1'b0;
			end
		end else begin
			vld_q[0] <= phase_in.valid;
			for (int i = 0; i < N; i++) begin
				vld_q[i+1] <= vld_q[i];
			end
		end
	end

	always_ff @(posedge tx_clk_b) begin
		// quadrant fold
		// odd quadrants start on the y axis so y ends as cos
		tag_q[0] <= '{last: phase_in.last, idx: phase_in.idx, neg: phase_in.phase[31]};
		x_q[0] <= phase_in.phase[30] ? XY_W'(0) : XY_W'(START_MAG);
		y_q[0] <= phase_in.phase[30] ? XY_W'(START_MAG) : XY_W'(0);
		// residual angle inside the quadrant
		z_q[0] <= {2'b00, phase_in.phase[29:0]};
		for (int i = 0; i < N; i++) begin
			tag_q[i+1] <= tag_q[i];
			if (z_q[i][31]) begin
				// angle overshot, rotate back
				x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
				z_q[i+1] <= z_q[i] + ATAN[i];
			end else begin
				x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
				z_q[i+1] <= z_q[i] - ATAN[i];
			end
		end
	end

	// lower half turn is the mirror of the upper
	assign y_fin = tag_q[N].neg ? -y_q[N] : y_q[N];

	assign sine_out = '{
		valid: vld_q[N],
		last: tag_q[N].last,
		idx: tag_q[N].idx,
		sample: y_fin[FRAC +: 16]
	};

endmodule

// File: hdl/frame_serializer.sv
`timescale 1ns/1ps
`include "adc_stream_config.svh"

module frame_serializer (
	input logic tx_clk_b,
	input logic rst_n,
	input adc_stream_pkg::tone_sample_t sine_in,
	output logic adc_ok,
	output adc_stream_pkg::byte_t adc_byte
);

	// channel to tone order of the board's test frame
	localparam adc_stream_pkg::tone_idx_t CH_MAP [`ADC_CHANNEL_COUNT] = '{
		3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7,
		3'd0, 3'd1, 3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2,
		3'd1, 3'd6, 3'd5, 3'd0, 3'd2, 3'd4, 3'd7, 3'd5,
		3'd6, 3'd1, 3'd3, 3'd7, 3'd1, 3'd5, 3'd6, 3'd0
	};

	adc_stream_pkg::sample_t tone_tab [`ADC_TONE_COUNT];
	adc_stream_pkg::sample_t frame_buf [`ADC_TONE_COUNT];
	adc_stream_pkg::ser_state_e state_q;
	logic [5:0] byte_cnt;
	logic frame_start;
	adc_stream_pkg::sample_t cur_word;

	// frame starts on tone 7, only when idle
	assign frame_start = sine_in.valid && sine_in.last && (state_q == adc_stream_pkg::ser_idle);

	// collect samples, snapshot the set on last
	always_ff @(posedge tx_clk_b) begin
		if (sine_in.valid) begin
			tone_tab[sine_in.idx] <= sine_in.sample;
		end
		if (frame_start) begin
			// incoming sample bypasses the table
			for (int t = 0; t < `ADC_TONE_COUNT; t++) begin
				if (sine_in.idx == 3'(t)) begin
					frame_buf[t] <= sine_in.sample;
				end else begin
					frame_buf[t] <= tone_tab[t];
				end
			end
		end
	end

	// output FSM, 64 bytes per frame
	always_ff @(posedge tx_clk_b) begin
		if (!rst_n) begin
			state_q <= adc_stream_pkg::ser_idle;
			byte_cnt <= '0;
		end else begin
			case (state_q)
				adc_stream_pkg::ser_idle: begin
					byte_cnt <= '0;
					if (frame_start) begin
						state_q <= adc_stream_pkg::ser_send;
					end
				end
				adc_stream_pkg::ser_send: begin
					byte_cnt <= byte_cnt + 6'd1;
					// last byte of channel 32
					if (byte_cnt == 6'd63) begin
						state_q <= adc_stream_pkg::ser_idle;
					end
				end
				default: state_q <= adc_stream_pkg::ser_idle;
			endcase
		end
	end

	// two bytes per channel
	assign cur_word = frame_buf[CH_MAP[byte_cnt[5:1]]];
	// low byte first
	assign adc_byte = byte_cnt[0] ? cur_word[15:8] : cur_word[7:0];
	assign adc_ok = (state_q == adc_stream_pkg::ser_send);

endmodule

// File: hdl/net_addr_select.sv
`timescale 1ns/1ps
`include "adc_stream_config.svh"

module net_addr_select (
	input logic tx_clk_b,
	input logic rst_n,
	input adc_stream_pkg::jumper_t ip_jumpers,
	output adc_stream_pkg::net_addr_t local_addr
);

	adc_stream_pkg::jumper_t host;

	// fitted jumper pulls low
	assign host = ~ip_jumpers;

	always_ff @(posedge tx_clk_b) begin
		if (!rst_n) begin
			local_addr.ip <= {`NET_IP_PREFIX, `NET_IP_DEFAULT_HOST};
			local_addr.mac <= {`NET_MAC_PREFIX, 8'h00};
		end else begin
			// no jumper fitted, fall back to .100
			if (host == '0) begin
				local_addr.ip <= {`NET_IP_PREFIX, `NET_IP_DEFAULT_HOST};
			end else begin
				local_addr.ip <= {`NET_IP_PREFIX, 3'b000, host};
			end
			// MAC low byte follows the jumpers, even when zero
			local_addr.mac <= {`NET_MAC_PREFIX, 3'b000, host};
		end
	end

endmodule

// File: hdl/adc_stream_top.sv
`timescale 1ns/1ps

module adc_stream_top (
	input logic tx_clk_b,
	input logic rst_n,
	input logic sample_tick,
	input adc_stream_pkg::jumper_t ip_jumpers,
	output logic adc_ok,
	output adc_stream_pkg::byte_t adc_byte,
	output adc_stream_pkg::net_addr_t local_addr
);

	// phases, one tone per cycle
	adc_stream_pkg::tone_phase_t tone_phase;
	// sines in the same order
	adc_stream_pkg::tone_sample_t tone_sine;

	// tick to phases
	tone_phase_gen tone_phase_gen_i (
		.tx_clk_b (tx_clk_b),
		.rst_n (rst_n),
		.sample_tick (sample_tick),
		.phase_out (tone_phase)
	);

	// phases to sines, 17 cycles
	cordic_sine cordic_sine_i (
		.tx_clk_b (tx_clk_b),
		.rst_n (rst_n),
		.phase_in (tone_phase),
		.sine_out (tone_sine)
	);

	// sines to the MAC byte stream
	frame_serializer frame_serializer_i (
		.tx_clk_b (tx_clk_b),
		.rst_n (rst_n),
		.sine_in (tone_sine),
		.adc_ok (adc_ok),
		.adc_byte (adc_byte)
	);

	// address from jumpers, beside the pipeline
	net_addr_select net_addr_select_i (
		.tx_clk_b (tx_clk_b),
		.rst_n (rst_n),
		.ip_jumpers (ip_jumpers),
		.local_addr (local_addr)
	);

endmodule

// File: testbench/tb_adc_stream.sv
`timescale 1ns/1ps
`include "adc_stream_config.svh"

module tb_adc_stream;

	localparam int NUM_TICKS = 20;
	// window for the first adc_ok after a tick
	localparam int LAT_LIMIT = 40;
	// allowed sine error in LSB
	localparam int TOL = 8;
	localparam real PI = 3.14159265358979;

	// channel to tone order of the test frame
	localparam int CH_TONE [32] = '{
		0, 1, 2, 3, 4, 5, 6, 7, 0, 1, 7, 6, 5, 4, 3, 2,
		1, 6, 5, 0, 2, 4, 7, 5, 6, 1, 3, 7, 1, 5, 6, 0
	};
	localparam logic [31:0] TONE_STEP [8] = '{
		`TONE_INC_0, `TONE_INC_1, `TONE_INC_2, `TONE_INC_3,
		`TONE_INC_4, `TONE_INC_5, `TONE_INC_6, `TONE_INC_7
	};

	logic tx_clk_b;
	logic rst_n;
	logic sample_tick;
	adc_stream_pkg::jumper_t ip_jumpers;
	logic adc_ok;
	adc_stream_pkg::byte_t adc_byte;
	adc_stream_pkg::net_addr_t local_addr;

	// reference model state
	logic [31:0] ref_phase [8];
	int expect_sine [8];
	logic [7:0] frame_bytes [64];
	logic [31:0] rng_state;
	// failed checks per test number
	int test_errs [1:5];

	adc_stream_top adc_stream_top_i (
		.tx_clk_b (tx_clk_b),
		.rst_n (rst_n),
		.sample_tick (sample_tick),
		.ip_jumpers (ip_jumpers),
		.adc_ok (adc_ok),
		.adc_byte (adc_byte),
		.local_addr (local_addr)
	);

	initial begin
		tx_clk_b = 1'b0;
		forever #10 tx_clk_b = ~tx_clk_b;
	end

	// sample and drive point 2 ns past the rising edge
	task automatic next_cycle();
		@(posedge tx_clk_b);
		#2;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// ideal sample for a phase where a full turn is 2^32
	function automatic int sine_of_phase(input logic [31:0] ph);
		real ang;
		ang = 2.0 * PI * real'(ph) / 4294967296.0;
		return $rtoi($floor(real'(`ADC_AMPLITUDE) * $sin(ang) + 0.5));
	endfunction

	task automatic report_test(input int no, input string name);
		if (test_errs[no] == 0) begin
			$display("test %0d %s: ok", no, name);
		end else begin
			$display("test %0d %s: %0d errors", no, name, test_errs[no]);
		end
	endtask

	// test 1 wants quiet output without ticks
	task automatic check_idle_after_reset();
		for (int n = 0; n < 200; n++) begin
			next_cycle();
			assert (!adc_ok) else begin
				test_errs[1]++;
				$display("[FAIL] adc_ok: got 0x%h, expected 0x0 at idle cycle %0d",
					adc_ok, n);
				break;
			end
		end
	endtask

	// tests 3 and 4 on one captured frame
	task automatic check_frame(input int tick_no);
		logic signed [15:0] w;
		logic signed [15:0] first_word [8];
		bit seen [8];
		int tone;
		int diff;
		for (int t = 0; t < 8; t++) begin
			seen[t] = 1'b0;
		end
		for (int c = 0; c < 32; c++) begin
			// low byte comes first
			w = {frame_bytes[2*c+1], frame_bytes[2*c]};
			tone = CH_TONE[c];
			diff = int'(w) - expect_sine[tone];
			assert (diff <= TOL && diff >= -TOL) else begin
				test_errs[3]++;
				$display("[FAIL] adc_byte channel %0d tick %0d: got 0x%h, expected 0x%h",
					c, tick_no, w, 16'(expect_sine[tone]));
			end
			if (!seen[tone]) begin
				first_word[tone] = w;
				seen[tone] = 1'b1;
			end else begin
				assert (w == first_word[tone]) else begin
					test_errs[4]++;
					$display("[FAIL] adc_byte channel %0d tick %0d: got 0x%h, expected 0x%h",
						c, tick_no, w, first_word[tone]);
				end
			end
		end
	endtask

	// one tick and its burst then the quiet gap up to the next tick
	task automatic run_tick(input int spacing, input int tick_no);
		int wait_cnt;
		int burst_len;
		int used;
		for (int t = 0; t < 8; t++) begin
			ref_phase[t] = ref_phase[t] + TONE_STEP[t];
			expect_sine[t] = sine_of_phase(ref_phase[t]);
		end
		sample_tick = 1'b1;
		next_cycle();
		sample_tick = 1'b0;
		wait_cnt = 1;
		while (!adc_ok && wait_cnt < LAT_LIMIT) begin
			next_cycle();
			wait_cnt++;
		end
		assert (adc_ok) else begin
			test_errs[2]++;
			$display("[FAIL] no adc_ok burst within %0d cycles of tick %0d",
				LAT_LIMIT, tick_no);
		end
		burst_len = 0;
		while (adc_ok && burst_len < 70) begin
			if (burst_len < 64) begin
				frame_bytes[burst_len] = adc_byte;
			end
			burst_len++;
			next_cycle();
		end
		if (burst_len > 0) begin
			assert (burst_len == 64) else begin
				test_errs[2]++;
				$display("[FAIL] adc_ok burst of tick %0d lasted %0d cycles instead of 64",
					tick_no, burst_len);
			end
		end
		if (burst_len == 64) begin
			check_frame(tick_no);
		end
		// nothing more until the next tick
		used = wait_cnt + burst_len;
		while (used < spacing) begin
			assert (!adc_ok) else begin
				test_errs[2]++;
				$display("[FAIL] second adc_ok burst after tick %0d", tick_no);
				break;
			end
			next_cycle();
			used++;
		end
	endtask

	// test 5 maps jumpers to the address
	task automatic check_addr();
		adc_stream_pkg::jumper_t j;
		int host_no;
		adc_stream_pkg::ipv4_t exp_ip;
		adc_stream_pkg::mac_t exp_mac;
		bit matched;
		int k;
		ip_jumpers = 5'h1f;
		next_cycle();
		next_cycle();
		exp_ip = {`NET_IP_PREFIX, `NET_IP_DEFAULT_HOST};
		exp_mac = {`NET_MAC_PREFIX, 8'h00};
		assert (local_addr.ip == exp_ip) else begin
			test_errs[5]++;
			$display("[FAIL] local_addr.ip: got 0x%h, expected 0x%h", local_addr.ip, exp_ip);
		end
		assert (local_addr.mac == exp_mac) else begin
			test_errs[5]++;
			$display("[FAIL] local_addr.mac: got 0x%h, expected 0x%h", local_addr.mac, exp_mac);
		end
		for (int n = 0; n < 24; n++) begin
			rng_state = xorshift32(rng_state);
			j = rng_state[4:0];
			// jumpers are active low so the host number is 31 minus the jumper value
			host_no = 31 - int'(j);
			exp_mac = {`NET_MAC_PREFIX, 8'(host_no)};
			if (host_no == 0) begin
				exp_ip = {`NET_IP_PREFIX, `NET_IP_DEFAULT_HOST};
			end else begin
				exp_ip = {`NET_IP_PREFIX, 8'(host_no)};
			end
			ip_jumpers = j;
			matched = 1'b0;
			k = 0;
			while (!matched && k < 2) begin
				next_cycle();
				k++;
				matched = (local_addr.ip == exp_ip) && (local_addr.mac == exp_mac);
			end
			assert (matched) else begin
				test_errs[5]++;
				$display("[FAIL] local_addr for ip_jumpers 0x%h: got 0x%h_%h, expected 0x%h_%h",
					j, local_addr.ip, local_addr.mac, exp_ip, exp_mac);
			end
		end
	endtask

	initial begin
		int spacing;
		int total;
		rng_state = 32'd85469;
		sample_tick = 1'b0;
		ip_jumpers = 5'h1f;
		rst_n = 1'b0;
		for (int t = 0; t < 8; t++) begin
			ref_phase[t] = '0;
			expect_sine[t] = 0;
		end
		for (int n = 1; n < 6; n++) begin
			test_errs[n] = 0;
		end
		repeat (10) next_cycle();
		rst_n = 1'b1;

		check_idle_after_reset();
		report_test(1, "idle after reset");

		// random tick spacing of 100 to 300 cycles
		for (int i = 0; i < NUM_TICKS; i++) begin
			rng_state = xorshift32(rng_state);
			spacing = 100 + int'(rng_state % 32'd201);
			run_tick(spacing, i);
		end
		report_test(2, "one burst per tick");
		report_test(3, "channel sine values");
		report_test(4, "shared tone channels");

		check_addr();
		report_test(5, "address from jumpers");

		total = 0;
		for (int n = 1; n < 6; n++) begin
			total += test_errs[n];
		end
		$display("5 tests run, %0d checks failed", total);
		if (total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+hdl
hdl/adc_stream_pkg.sv
hdl/tone_phase_gen.sv
hdl/cordic_sine.sv
hdl/frame_serializer.sv
hdl/net_addr_select.sv
hdl/adc_stream_top.sv
testbench/tb_adc_stream.sv

// File: Bender.yml
package:
  name: adc_stream

export_include_dirs:
  - hdl

sources:
  - hdl/adc_stream_pkg.sv
  - hdl/tone_phase_gen.sv
  - hdl/cordic_sine.sv
  - hdl/frame_serializer.sv
  - hdl/net_addr_select.sv
  - hdl/adc_stream_top.sv
  - target: test
    files:
      - testbench/tb_adc_stream.sv
